// File: sources.f
+incdir+design
design/tau_pkg.sv
design/rdyack_forward.sv
design/dual_warp_issuer.sv
design/stencil_cfg_regs.sv
design/warp_stencil_stage.sv
design/warp_stencil_top.sv
verif/tb_warp_stencil.sv

// File: run.sh
#!/bin/bash
# Build the warp stencil testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	-f sources.f --top-module tb_warp_stencil -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: verif/tb_warp_stencil.sv
// Testbench for the warp address stage
// Drives commands and config writes, checks every output beat against a model
`include "tau_defines.svh"

module tb_warp_stencil;
	timeunit 1ns;
	timeprecision 1ps;

	logic                  i_clk;
	logic                  i_rst_n;
	logic                  i_cmd_rdy;
	logic                  o_cmd_ack;
	tau_pkg::block_cmd_t   i_cmd;
	logic                  i_cfg_we;
	tau_pkg::cfg_sel_e     i_cfg_sel;
	logic [`TAU_ST_BW-1:0] i_cfg_addr;
	logic [`TAU_ABW-1:0]   i_cfg_wdata;
	logic                  o_out_rdy;
	logic                  i_out_ack;
	tau_pkg::warp_beat_t   o_out;

	// Shadow copy of the configuration kept by the config write task
	logic                  sh_en [`TAU_N_CFG];
	int                    sh_beg [`TAU_N_CFG];
	int                    sh_end [`TAU_N_CFG];
	logic [`TAU_ABW-1:0]   sh_lut [`TAU_STSIZE];
	// Expected beats in output order
	tau_pkg::warp_beat_t   exp_q [$];
	integer                seed;
	// Separate random stream for the output ack
	integer                ack_seed;
	string                 cur_test;
	logic                  ack_random;
	int                    n_tests;
	int                    n_checks;
	int                    n_errors;
	int                    err_base;
	int                    beats_seen;
	int                    islast_seen;
	int                    islast_exp;
	int                    total_beats;
	int                    cycles;

	warp_stencil_top UUT (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cmd_rdy   (i_cmd_rdy),
		.o_cmd_ack   (o_cmd_ack),
		.i_cmd       (i_cmd),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_sel   (i_cfg_sel),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.o_out_rdy   (o_out_rdy),
		.i_out_ack   (i_out_ack),
		.o_out       (o_out)
	);

	// 4 ns clock
	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// ==========================================================================
	// Reference model and checks
	// ==========================================================================
	// Expands one command into its beats with the current shadow config
	function automatic void expand_cmd(input tau_pkg::block_cmd_t c);
		int                  npairs;
		int                  lo;
		int                  hi;
		logic                last;
		logic [`TAU_ABW-1:0] lin0;
		logic [`TAU_ABW-1:0] ofs;
		tau_pkg::warp_beat_t b;
		npairs = (c.n_warp == 0) ? 1 : int'(c.n_warp);
		// Disabled ids behave as a single point with no offset
		lo = sh_en[c.id] ? sh_beg[c.id] : 0;
		hi = sh_en[c.id] ? sh_end[c.id] : 1;
		for (int k = 0; k < npairs; k++) begin
			lin0 = c.base + 32'(2 * k * `TAU_WARP_STRIDE);
			for (int s = lo; s < hi; s++) begin
				ofs      = sh_en[c.id] ? sh_lut[s] : '0;
				last     = (k == npairs - 1) && (s == hi - 1);
				b.id     = c.id;
				b.bofs   = c.bofs;
				b.retire = 1'b0;
				b.islast = 1'b0;
				b.linear = lin0 + ofs;
				exp_q.push_back(b);
				// Upper warp carries the flags on the very last beat only
				b.linear = lin0 + 32'(`TAU_WARP_STRIDE) + ofs;
				b.retire = c.retire && last;
				b.islast = c.islast && last;
				exp_q.push_back(b);
				total_beats += 2;
			end
		end
		if (c.islast) islast_exp++;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		n_checks++;
		if (exp_v !== act_v) begin
			$display("error %s expected %h actual %h", name, exp_v, act_v);
			n_errors++;
		end
	endtask

	// Output ack driver and comparing process on the falling edge
	initial begin : out_monitor
		tau_pkg::warp_beat_t exp_b;
		logic [31:0]         r;
		i_out_ack = 1'b0;
		ack_seed  = 20;
		@(posedge i_rst_n);
		forever begin
			@(negedge i_clk);
			r = $random(ack_seed);
			i_out_ack = ack_random ? r[0] : 1'b1;
			// Output register is stable here and the transfer happens at the next rise
			if (o_out_rdy && i_out_ack) begin
				beats_seen++;
				if (o_out.islast) islast_seen++;
				if (exp_q.size() == 0) begin
					$display("test %s: beat came out when none was expected", cur_test);
					n_errors++;
				end else begin
					exp_b = exp_q.pop_front();
					check_value(cur_test, exp_b, o_out);
				end
			end
		end
	end

	// Limit grows with the beats queued so far
	initial begin : watchdog
		cycles = 0;
		while (cycles <= 8 * total_beats + 2000) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("timeout after %0d cycles in test %s, output stalled", cycles, cur_test);
		$display("=== FAIL ===");
		$finish;
	end

	// ==========================================================================
	// Stimulus tasks
	// ==========================================================================
	task automatic write_cfg(input tau_pkg::cfg_sel_e sel, input int addr,
			input logic [31:0] data);
		@(negedge i_clk);
		i_cfg_we    = 1'b1;
		i_cfg_sel   = sel;
		i_cfg_addr  = addr[`TAU_ST_BW-1:0];
		i_cfg_wdata = data;
		case (sel)
			tau_pkg::CFG_ENABLE: sh_en[addr] = data[0];
			tau_pkg::CFG_BEGS:   sh_beg[addr] = int'(data[`TAU_ST_BW-1:0]);
			tau_pkg::CFG_ENDS:   sh_end[addr] = int'(data[`TAU_ST_BW-1:0]);
			default:             sh_lut[addr] = data;
		endcase
		@(negedge i_clk);
		i_cfg_we = 1'b0;
	endtask

	task automatic setup_id(input int id, input logic en, input int beg, input int fin);
		write_cfg(tau_pkg::CFG_BEGS, id, beg);
		write_cfg(tau_pkg::CFG_ENDS, id, fin);
		write_cfg(tau_pkg::CFG_ENABLE, id, {31'b0, en});
	endtask

	// Leaves rdy high after the transfer while the issuer is busy
	task automatic send_cmd(input tau_pkg::block_cmd_t c);
		logic acked;
		expand_cmd(c);
		@(negedge i_clk);
		i_cmd     = c;
		i_cmd_rdy = 1'b1;
		acked     = o_cmd_ack;
		while (!acked) begin
			@(negedge i_clk);
			acked = o_cmd_ack;
		end
		@(posedge i_clk);
	endtask

	task automatic release_cmd();
		@(negedge i_clk);
		i_cmd_rdy = 1'b0;
	endtask

	function automatic tau_pkg::block_cmd_t build_cmd(input int id, input logic [31:0] base,
			input int n_warp, input logic retire, input logic islast);
		tau_pkg::block_cmd_t c;
		c.id     = id[`TAU_NCFG_BW-1:0];
		c.base   = base;
		c.bofs   = {base[15:8] ^ 8'h3c, 8'(id + n_warp)};
		c.n_warp = n_warp[`TAU_NWARP_BW-1:0];
		c.retire = retire;
		c.islast = islast;
		return c;
	endfunction

	task automatic rand_cmd(output tau_pkg::block_cmd_t c);
		logic [31:0] r;
		r = $random(seed);
		c = build_cmd(int'(r[1:0]), $random(seed), int'(r[4:2]), r[5], r[6]);
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		err_base    = n_errors;
		beats_seen  = 0;
		islast_seen = 0;
		islast_exp  = 0;
	endtask

	// Waits a bounded time for the model queue to drain
	// A short guard afterwards catches extra beats
	task automatic finish_test();
		int limit;
		int waited;
		limit  = 8 * exp_q.size() + 200;
		waited = 0;
		while (exp_q.size() != 0 && waited < limit) begin
			@(negedge i_clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("test %s: %0d expected beats never came out of the DUT", cur_test,
				exp_q.size());
			n_errors++;
			exp_q.delete();
		end
		repeat (6) @(negedge i_clk);
		check_value({cur_test, " islast count"}, islast_exp, islast_seen);
		n_tests++;
		$display("test %s finished: %0d beats, %0d errors", cur_test, beats_seen,
			n_errors - err_base);
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================
	initial begin : stimulus
		tau_pkg::block_cmd_t c;
		seed        = 20;
		ack_random  = 1'b0;
		n_tests     = 0;
		n_checks    = 0;
		n_errors    = 0;
		total_beats = 0;
		i_rst_n     = 1'b0;
		i_cmd_rdy   = 1'b0;
		i_cmd       = '0;
		i_cfg_we    = 1'b0;
		i_cfg_sel   = tau_pkg::CFG_ENABLE;
		i_cfg_addr  = '0;
		i_cfg_wdata = '0;
		for (int i = 0; i < `TAU_N_CFG; i++) begin
			sh_en[i]  = 1'b0;
			sh_beg[i] = 0;
			sh_end[i] = 0;
		end
		for (int i = 0; i < `TAU_STSIZE; i++) sh_lut[i] = '0;

		// Quiet ports in reset and the command port opens one cycle after release
		start_test("reset");
		repeat (10) @(posedge i_clk);
		@(negedge i_clk);
		check_value("reset cmd_ack", 1'b0, o_cmd_ack);
		check_value("reset out_rdy", 1'b0, o_out_rdy);
		i_rst_n = 1'b1;
		@(negedge i_clk);
		check_value("reset cmd_ack", 1'b1, o_cmd_ack);
		finish_test();

		// Stencil off after reset gives plain pairs
		start_test("disabled");
		send_cmd(build_cmd(0, 32'h0000_1000, 3, 1'b1, 1'b1));
		release_cmd();
		send_cmd(build_cmd(0, 32'h0000_2400, 0, 1'b0, 1'b1));
		release_cmd();
		finish_test();

		// Random LUT and one id with a middle range
		start_test("stencil_on");
		for (int i = 0; i < `TAU_STSIZE; i++) write_cfg(tau_pkg::CFG_LUT, i, $random(seed));
		setup_id(1, 1'b1, 2, 5);
		send_cmd(build_cmd(1, 32'h8000_0040, 2, 1'b1, 1'b1));
		release_cmd();
		finish_test();

		// Full range, single point, and the still disabled id 0
		start_test("per_id");
		setup_id(2, 1'b1, 0, 8);
		setup_id(3, 1'b1, 6, 7);
		send_cmd(build_cmd(2, 32'h0010_0000, 1, 1'b0, 1'b1));
		release_cmd();
		send_cmd(build_cmd(3, 32'h0020_0100, 2, 1'b1, 1'b0));
		release_cmd();
		send_cmd(build_cmd(0, 32'h0030_0000, 2, 1'b1, 1'b1));
		release_cmd();
		send_cmd(build_cmd(1, 32'hffff_ffe0, 1, 1'b1, 1'b1));
		release_cmd();
		finish_test();

		// Output back-pressure at about half duty
		start_test("random_ack");
		ack_random = 1'b1;
		for (int i = 0; i < 6; i++) begin
			rand_cmd(c);
			send_cmd(c);
			release_cmd();
		end
		finish_test();
		ack_random = 1'b0;

		// Command rdy stays high across commands
		start_test("back_to_back");
		for (int i = 0; i < 6; i++) begin
			rand_cmd(c);
			send_cmd(c);
		end
		release_cmd();
		finish_test();

		$display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: design/warp_stencil_top.sv
// Warp address stage top level
// Issuer, config registers, stencil stage and output register in a chain
`include "tau_defines.svh"

module warp_stencil_top (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	// Command stream
	input  logic                  i_cmd_rdy,
	output logic                  o_cmd_ack,
	input  tau_pkg::block_cmd_t   i_cmd,
	// Config write port
	input  logic                  i_cfg_we,
	input  tau_pkg::cfg_sel_e     i_cfg_sel,
	input  logic [`TAU_ST_BW-1:0] i_cfg_addr,
	input  logic [`TAU_ABW-1:0]   i_cfg_wdata,
	// Output stream
	output logic                  o_out_rdy,
	input  logic                  i_out_ack,
	output tau_pkg::warp_beat_t   o_out
);

	// Issuer to stage
	logic                  beat_rdy;
	logic                  beat_ack;
	tau_pkg::warp_beat_t   beat;
	// Stage to output register
	logic                  st_rdy;
	logic                  st_ack;
	tau_pkg::warp_beat_t   st_beat;
	// Configuration level
	tau_pkg::stencil_cfg_t cfg;

	dual_warp_issuer u_issuer (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_cmd_rdy  (i_cmd_rdy),
		.o_cmd_ack  (o_cmd_ack),
		.i_cmd      (i_cmd),
		.o_beat_rdy (beat_rdy),
		.i_beat_ack (beat_ack),
		.o_beat     (beat)
	);

	stencil_cfg_regs u_cfg (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_sel   (i_cfg_sel),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.o_cfg       (cfg)
	);

	warp_stencil_stage u_stage (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_src_rdy (beat_rdy),
		.o_src_ack (beat_ack),
		.i_src     (beat),
		.i_cfg     (cfg),
		.o_dst_rdy (st_rdy),
		.i_dst_ack (st_ack),
		.o_dst     (st_beat)
	);

	// Output slice, one cycle
	rdyack_forward #(
		.T(tau_pkg::warp_beat_t)
	) u_out_fwd (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (st_rdy),
		.o_src_ack  (st_ack),
		.i_src_data (st_beat),
		.o_dst_rdy  (o_out_rdy),
		.i_dst_ack  (i_out_ack),
		.o_dst_data (o_out)
	);

endmodule

// File: design/warp_stencil_stage.sv
// Warp stencil stage
// Pairs up lower and upper beats and replays them over the stencil range
`include "tau_defines.svh"

module warp_stencil_stage (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_src_rdy,
	output logic                  o_src_ack,
	input  tau_pkg::warp_beat_t   i_src,
	input  tau_pkg::stencil_cfg_t i_cfg,
	output logic                  o_dst_rdy,
	input  logic                  i_dst_ack,
	output tau_pkg::warp_beat_t   o_dst
);

	localparam int ST_BW = `TAU_ST_BW;

	// ======================================================================
	// Signals
	// ======================================================================
	// Single-beat buffer for the lower warp
	logic                  single_rdy_r;
	logic [`TAU_ABW-1:0]   single_linear_r;
	// Pair stream into the forward register
	logic                  pair_rdy;
	logic                  pair_ack;
	tau_pkg::warp_pair_t   pair_in;
	// Pair held for replay
	logic                  s1_rdy;
	logic                  s1_ack;
	tau_pkg::warp_pair_t   s1_pair;
	// Replay state
	logic                  warp_hi_r;
	logic [ST_BW-1:0]      sid_r;
	logic [ST_BW-1:0]      sid1;
	logic                  st_en;
	logic                  last_stencil;
	logic                  done_cond;
	logic                  dst_xfer;

	// ======================================================================
	// Pair collection
	// ======================================================================
	// Second beat passes only when the forward register takes the pair
	assign pair_rdy  = single_rdy_r && i_src_rdy;
	assign o_src_ack = pair_ack || (i_src_rdy && !single_rdy_r);

	always_comb begin
		pair_in.id         = i_src.id;
		pair_in.linears[0] = single_linear_r;
		pair_in.linears[1] = i_src.linear;
		pair_in.bofs       = i_src.bofs;
		// Flags come from the upper beat
		pair_in.retire     = i_src.retire;
		pair_in.islast     = i_src.islast;
	end

	// Buffer full flag
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			single_rdy_r <= 1'b0;
		end else if (single_rdy_r) begin
			// Empties only when the pair really transfers
			single_rdy_r <= !(pair_rdy && pair_ack);
		end else begin
			single_rdy_r <= i_src_rdy;
		end
	end

	// Lower linear captured on the first beat
	always_ff @(posedge i_clk) begin
		if (!single_rdy_r && i_src_rdy) begin
			single_linear_r <= i_src.linear;
		end
	end

	rdyack_forward #(
		.T(tau_pkg::warp_pair_t)
	) u_pair_fwd (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (pair_rdy),
		.o_src_ack  (pair_ack),
		.i_src_data (pair_in),
		.o_dst_rdy  (s1_rdy),
		.i_dst_ack  (s1_ack),
		.o_dst_data (s1_pair)
	);

	// ======================================================================
	// Replay
	// ======================================================================
	// Every output beat leaves with the downstream ack
	// The pair is released on the done condition
	assign o_dst_rdy = s1_rdy;
	assign dst_xfer  = s1_rdy && i_dst_ack;
	assign s1_ack    = i_dst_ack && done_cond;

	always_comb begin
		st_en        = i_cfg.enable[s1_pair.id];
		sid1         = sid_r + ST_BW'(1);
		last_stencil = (sid1 == i_cfg.ends[s1_pair.id]);
		// Done only on an upper beat
		done_cond    = (!st_en || last_stencil) && warp_hi_r;
		o_dst.id     = s1_pair.id;
		o_dst.linear = s1_pair.linears[warp_hi_r] + (st_en ? i_cfg.lut[sid_r] : '0);
		o_dst.bofs   = s1_pair.bofs;
		o_dst.retire = s1_pair.retire && done_cond;
		o_dst.islast = s1_pair.islast && done_cond;
	end

	// Lower or upper half of the pair
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			warp_hi_r <= 1'b0;
		end else if (dst_xfer) begin
			warp_hi_r <= !warp_hi_r;
		end
	end

	// Pair entry loads begs into the stencil index before any advance
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sid_r <= '0;
		end else if (pair_rdy && pair_ack) begin
			sid_r <= i_cfg.begs[i_src.id];
		end else if (dst_xfer && warp_hi_r) begin
			sid_r <= sid1;
		end
	end

endmodule

// File: design/stencil_cfg_regs.sv
// Stencil configuration registers
// Per-id enable, begin and end indices, plus the shared offset LUT
`include "tau_defines.svh"

module stencil_cfg_regs (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_cfg_we,
	input  tau_pkg::cfg_sel_e     i_cfg_sel,
	input  logic [`TAU_ST_BW-1:0] i_cfg_addr,
	input  logic [`TAU_ABW-1:0]   i_cfg_wdata,
	output tau_pkg::stencil_cfg_t o_cfg
);

	tau_pkg::stencil_cfg_t cfg_r;

	// Stage reads the whole configuration as a level
	assign o_cfg = cfg_r;

	// ======================================================================
	// Write decode
	// ======================================================================
	// Address picks the id or the LUT entry
	// Data is cut to the field width
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			// All ids come up with the stencil off
			cfg_r <= '0;
		end else if (i_cfg_we) begin
			case (i_cfg_sel)
				tau_pkg::CFG_ENABLE: begin
					for (int i = 0; i < `TAU_N_CFG; i++) begin
						if (i_cfg_addr == i) begin
							cfg_r.enable[i] <= i_cfg_wdata[0];
						end
					end
				end
				tau_pkg::CFG_BEGS: begin
					for (int i = 0; i < `TAU_N_CFG; i++) begin
						if (i_cfg_addr == i) begin
							cfg_r.begs[i] <= i_cfg_wdata[`TAU_ST_BW-1:0];
						end
					end
				end
				tau_pkg::CFG_ENDS: begin
					for (int i = 0; i < `TAU_N_CFG; i++) begin
						if (i_cfg_addr == i) begin
							cfg_r.ends[i] <= i_cfg_wdata[`TAU_ST_BW-1:0];
						end
					end
				end
				tau_pkg::CFG_LUT: begin
					// Address beyond the LUT writes nothing
					for (int i = 0; i < `TAU_STSIZE; i++) begin
						if (i_cfg_addr == i) begin
							cfg_r.lut[i] <= i_cfg_wdata;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: design/dual_warp_issuer.sv
// Dual warp issuer
// Turns one block command into lower and upper beats for each warp pair
`include "tau_defines.svh"

module dual_warp_issuer (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_cmd_rdy,
	output logic                o_cmd_ack,
	input  tau_pkg::block_cmd_t i_cmd,
	output logic                o_beat_rdy,
	input  logic                i_beat_ack,
	output tau_pkg::warp_beat_t o_beat
);

	// Init holds the command port closed for one cycle after reset
	typedef enum logic [1:0] {
		S_INIT,
		S_IDLE,
		S_RUN
	} state_e;

	state_e                    state_r;
	tau_pkg::block_cmd_t       cmd_r;
	logic [`TAU_NWARP_BW-1:0]  pair_r;
	logic                      half_r;
	logic [`TAU_NWARP_BW-1:0]  pair_last;
	logic                      last_pair;
	logic [`TAU_NWARP_BW:0]    warp_idx;
	logic                      cmd_xfer;
	logic                      beat_xfer;

	// ======================================================================
	// Handshake and beat fields
	// ======================================================================
	assign o_cmd_ack  = (state_r == S_IDLE);
	assign o_beat_rdy = (state_r == S_RUN);
	assign cmd_xfer   = i_cmd_rdy && o_cmd_ack;
	assign beat_xfer  = o_beat_rdy && i_beat_ack;

	always_comb begin
		// Zero pairs behaves as a single pair
		pair_last = (cmd_r.n_warp == '0) ? '0 : cmd_r.n_warp - 1'b1;
		last_pair = (pair_r == pair_last);
		// Warp number is 2k for the lower beat, 2k+1 for the upper
		warp_idx  = {pair_r, half_r};
		o_beat.id     = cmd_r.id;
		o_beat.linear = cmd_r.base + `TAU_ABW'(warp_idx) * `TAU_ABW'(`TAU_WARP_STRIDE);
		o_beat.bofs   = cmd_r.bofs;
		// Flags on both beats of the final pair, the stage narrows them
		o_beat.retire = cmd_r.retire && last_pair;
		o_beat.islast = cmd_r.islast && last_pair;
	end

	// ======================================================================
	// Control
	// ======================================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= S_INIT;
			pair_r  <= '0;
			half_r  <= 1'b0;
		end else begin
			case (state_r)
				S_INIT: state_r <= S_IDLE;
				S_IDLE: begin
					if (cmd_xfer) begin
						state_r <= S_RUN;
						pair_r  <= '0;
						half_r  <= 1'b0;
					end
				end
				S_RUN: begin
					if (beat_xfer) begin
						half_r <= !half_r;
						// Upper beat closes the pair
						if (half_r) begin
							if (last_pair) begin
								state_r <= S_IDLE;
							end else begin
								pair_r <= pair_r + 1'b1;
							end
						end
					end
				end
				default: state_r <= S_IDLE;
			endcase
		end
	end

	// Command latch
	always_ff @(posedge i_clk) begin
		if (cmd_xfer) begin
			cmd_r <= i_cmd;
		end
	end

endmodule

// File: design/rdyack_forward.sv
// One-deep rdy/ack register slice
// Payload type is a parameter, full throughput when drained every cycle
module rdyack_forward #(
	parameter type T = logic
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_src_rdy,
	output logic o_src_ack,
	input  T     i_src_data,
	output logic o_dst_rdy,
	input  logic i_dst_ack,
	output T     o_dst_data
);

	logic full_r;
	logic src_xfer;
	T     data_r;

	// Take new data when empty or when the held entry leaves now
	assign o_src_ack  = !full_r || i_dst_ack;
	assign src_xfer   = i_src_rdy && o_src_ack;
	assign o_dst_rdy  = full_r;
	assign o_dst_data = data_r;

	// Occupancy
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			full_r <= 1'b0;
		end else if (src_xfer) begin
			full_r <= 1'b1;
		end else if (i_dst_ack) begin
			full_r <= 1'b0;
		end
	end

	// Payload, loaded only on a source transfer
	always_ff @(posedge i_clk) begin
		if (src_xfer) begin
			data_r <= i_src_data;
		end
	end

endmodule

// File: design/tau_pkg.sv
// Shared types of the warp address stage
// Command, beat, beat pair and stencil configuration records
`include "tau_defines.svh"

package tau_pkg;

	// ======================================================================
	// Streams
	// ======================================================================
	// One block command from the outside
	typedef struct packed {
		logic [`TAU_NCFG_BW-1:0]            id;
		logic [`TAU_ABW-1:0]                base;
		logic [`TAU_VDIM-1:0][`TAU_WBW-1:0] bofs;
		// Number of warp pairs, zero counts as one
		logic [`TAU_NWARP_BW-1:0]           n_warp;
		logic                               retire;
		logic                               islast;
	} block_cmd_t;

	// One warp beat, issuer output and top output
	typedef struct packed {
		logic [`TAU_NCFG_BW-1:0]            id;
		logic [`TAU_ABW-1:0]                linear;
		logic [`TAU_VDIM-1:0][`TAU_WBW-1:0] bofs;
		logic                               retire;
		logic                               islast;
	} warp_beat_t;

	// Lower and upper beat merged, index 0 is the lower warp
	typedef struct packed {
		logic [`TAU_NCFG_BW-1:0]            id;
		logic [1:0][`TAU_ABW-1:0]           linears;
		logic [`TAU_VDIM-1:0][`TAU_WBW-1:0] bofs;
		logic                               retire;
		logic                               islast;
	} warp_pair_t;

	// ======================================================================
	// Configuration
	// ======================================================================
	// Write target of the config port
	typedef enum logic [1:0] {
		CFG_ENABLE,
		CFG_BEGS,
		CFG_ENDS,
		CFG_LUT
	} cfg_sel_e;

	// Whole stencil configuration as one flat record
	typedef struct packed {
		logic [`TAU_N_CFG-1:0]                   enable;
		logic [`TAU_N_CFG-1:0][`TAU_ST_BW-1:0]   begs;
		logic [`TAU_N_CFG-1:0][`TAU_ST_BW-1:0]   ends;
		logic [`TAU_STSIZE-1:0][`TAU_ABW-1:0]    lut;
	} stencil_cfg_t;

endpackage

// File: design/tau_defines.svh
// Size macros for the warp address stage
// Config count, address and offset widths, dimensions and stencil size
`ifndef TAU_DEFINES_SVH
`define TAU_DEFINES_SVH

// ==========================================================================
// Base sizes
// ==========================================================================
// Number of stencil configurations
`define TAU_N_CFG 4
// Linear address width
`define TAU_ABW 32
// Block offset width, one per dimension
`define TAU_WBW 8
// Number of block dimensions
`define TAU_VDIM 2
// Entries in the shared stencil offset LUT
`define TAU_STSIZE 8
// Address step from one warp to the next
`define TAU_WARP_STRIDE 32
// Width of the warp pair count
`define TAU_NWARP_BW 6

// ==========================================================================
// Derived widths
// ==========================================================================
// Config id width
`define TAU_NCFG_BW $clog2(`TAU_N_CFG)
// Stencil index width, wide enough to hold an end index of STSIZE
`define TAU_ST_BW $clog2(`TAU_STSIZE+1)

`endif
